/* Bender.yml */
package:
  name: stripe_buffer

export_include_dirs:
  - include

sources:
  - files:
      - verilog/stripe_data_pkg.sv
      - verilog/stripe_lane_pkg.sv
      - verilog/fifo_lane_if.sv
      - verilog/lane_fifo.sv
      - verilog/lane_distributor.sv
      - verilog/lane_collector.sv
      - verilog/stripe_buffer.sv
  - target: test
    files:
      - tests/stripe_buffer_sva.sv
      - tests/stripe_buffer_tb.sv

/* include/stripe_cfg.svh */
// Lane count must be a power of two and at least 2, and each lane holds 2**STRIPE_LG_DEPTH words
`ifndef STRIPE_CFG_SVH
`define STRIPE_CFG_SVH

//////////////////////////////////////////////////
// Striped buffer configuration
//////////////////////////////////////////////////

// Payload word width in bits
`define STRIPE_DATA_W 8

// Number of FIFO lanes, power of two
`define STRIPE_LANES 4

// Log2 of words per lane
// 3 gives 8 words per lane, 32 in total with 4 lanes
`define STRIPE_LG_DEPTH 3

`endif

/* tests/stripe_buffer_sva.sv */
// Bound into every lane_fifo and checked only while i_reset is low, so lane state during reset is not covered
`timescale 1ns/1ps
`default_nettype none

module stripe_buffer_sva (
	input  wire				i_clk,
	input  wire				i_reset,
	input  wire				i_wr,
	input  wire				i_rd,
	input  wire				i_full,
	input  wire				i_empty,
	input  stripe_lane_pkg::lane_fill_t	i_fill
);
	import stripe_lane_pkg::*;

	// Depth expressed in the lane fill type
	localparam lane_fill_t DEPTH_FILL = lane_fill_t'(LANE_DEPTH);

	// Count of failed assertions in this lane
	int fire_count = 0;

	//////////////////////////////////////////////////
	// Strobe legality
	//////////////////////////////////////////////////

	// Distributor must hold off a full lane
	a_no_write_full: assert property (@(posedge i_clk) disable iff (i_reset) i_wr |-> !i_full)
	else begin
		$error("write strobe on a full lane");
		fire_count = fire_count + 1;
	end

	// Collector must hold off an empty lane
	a_no_read_empty: assert property (@(posedge i_clk) disable iff (i_reset) i_rd |-> !i_empty)
	else begin
		$error("read strobe on an empty lane");
		fire_count = fire_count + 1;
	end

	//////////////////////////////////////////////////
	// Flag consistency
	//////////////////////////////////////////////////

	a_fill_in_range: assert property (@(posedge i_clk) disable iff (i_reset) i_fill <= DEPTH_FILL)
	else begin
		$error("lane fill above lane depth");
		fire_count = fire_count + 1;
	end

	// Registered full must track the registered fill
	a_full_matches: assert property (
		@(posedge i_clk) disable iff (i_reset) i_full == (i_fill == DEPTH_FILL)
	) else begin
		$error("lane full flag disagrees with lane fill");
		fire_count = fire_count + 1;
	end

endmodule

// Strobes are taken from the lane's own interface port
bind lane_fifo stripe_buffer_sva u_sva (
	.i_clk		(i_clk),
	.i_reset	(i_reset),
	.i_wr		(lane.wr),
	.i_rd		(lane.rd),
	.i_full		(lane.full),
	.i_empty	(lane.empty),
	.i_fill		(lane.fill)
);

`default_nettype wire

/* tests/stripe_buffer_tb.sv */
// Model assumes balanced lanes, so full means 32 words and empty means none, for the default cfg only
`timescale 1ns/1ps
`default_nettype none

`include "stripe_cfg.svh"

module stripe_buffer_tb;
	import stripe_data_pkg::*;
	import stripe_lane_pkg::*;

	localparam int CAPACITY = `STRIPE_LANES * (1 << `STRIPE_LG_DEPTH);
	localparam int RAND_CYCLES = 2000;
	// Directed tests need about 220 cycles
	localparam int TIMEOUT_CYCLES = RAND_CYCLES + 1000;

	logic		i_clk;
	logic		i_reset;
	logic		i_wr;
	logic		i_rd;
	word_t		i_data;
	logic		o_full;
	logic		o_empty;
	word_t		o_data;
	total_fill_t	o_fill;

	// Model contents and words sent by the directed tests
	word_t		model_q [$];
	word_t		sent_q [$];
	logic [31:0]	rng_state = 32'd39167;
	int		cycle_count = 0;
	string		test_name = "reset";
	logic [`STRIPE_LANES-1:0]	lane_sva_bad;

	stripe_buffer UUT (
		.i_clk(i_clk), .i_reset(i_reset), .i_wr(i_wr), .i_data(i_data), .o_full(o_full),
		.i_rd(i_rd), .o_data(o_data), .o_empty(o_empty), .o_fill(o_fill)
	);

	// Failure counters of the bound lane checkers
	for (genvar g = 0; g < `STRIPE_LANES; g++) begin : g_sva
		assign lane_sva_bad[g] = (UUT.g_lane[g].u_fifo.u_sva.fire_count != 0);
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic word_t expected_head();
		return model_q[0];
	endfunction

	function automatic total_fill_t expected_fill();
		return total_fill_t'(model_q.size());
	endfunction

	function automatic logic expected_full();
		return model_q.size() == CAPACITY;
	endfunction

	function automatic logic expected_empty();
		return model_q.size() == 0;
	endfunction

	// One clock edge of the buffer
	// acceptance judged on the flags before the edge
	task automatic model_step(input logic wr, input logic rd, input word_t data);
		logic wr_ok;
		logic rd_ok;
		wr_ok = wr && !expected_full();
		rd_ok = rd && !expected_empty();
		if (rd_ok) begin
			void'(model_q.pop_front());
		end
		if (wr_ok) begin
			model_q.push_back(data);
		end
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string what, input word_t act, input word_t exp);
		if (act !== exp) begin
			stop_on_error($sformatf("Fail %s %s: expected %h, actual %h", test_name, what, exp, act));
		end
	endtask

	task automatic check_fill(input string what, input total_fill_t act, input total_fill_t exp);
		if (act !== exp) begin
			stop_on_error($sformatf("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act));
		end
	endtask

	task automatic check_flag(input string what, input logic act, input logic exp);
		if (act !== exp) begin
			stop_on_error($sformatf("Fail %s %s: expected %b, actual %b", test_name, what, exp, act));
		end
	endtask

	// Outputs are settled at the falling edge and inputs are held for the next rising one
	always @(negedge i_clk) begin : compare_outputs
		if (i_reset) begin
			model_q.delete();
		end else begin
			check_flag("o_empty", o_empty, expected_empty());
			check_flag("o_full", o_full, expected_full());
			check_fill("o_fill", o_fill, expected_fill());
			if (!expected_empty()) begin
				check_word("o_data", o_data, expected_head());
			end
			if (lane_sva_bad != '0) begin
				stop_on_error("A bound lane assertion failed");
			end
			model_step(i_wr, i_rd, i_data);
		end
	end

	//////////////////////////////////////////////////
	// Clock and timeout
	//////////////////////////////////////////////////

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge i_clk);
			cycle_count++;
		end
		stop_on_error("Timeout: the run did not finish within the cycle limit");
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic drive(input logic wr, input logic rd, input word_t data);
		@(posedge i_clk);
		#1;
		i_wr = wr;
		i_rd = rd;
		i_data = data;
	endtask

	task automatic write_words(input int n);
		word_t w;
		for (int i = 0; i < n; i++) begin
			w = word_t'(next_rand());
			sent_q.push_back(w);
			drive(1'b1, 1'b0, w);
		end
		drive(1'b0, 1'b0, '0);
	endtask

	// Head word must be the oldest word sent
	task automatic drain_words(input int n);
		word_t exp;
		for (int i = 0; i < n; i++) begin
			drive(1'b0, 1'b1, '0);
			@(negedge i_clk);
			exp = sent_q.pop_front();
			check_flag("o_empty", o_empty, 1'b0);
			check_word("drained word", o_data, exp);
		end
		drive(1'b0, 1'b0, '0);
	endtask

	task automatic check_level(input total_fill_t fill, input logic full, input logic empty);
		@(negedge i_clk);
		check_fill("o_fill", o_fill, fill);
		check_flag("o_full", o_full, full);
		check_flag("o_empty", o_empty, empty);
	endtask

	initial begin
		logic [31:0] r;
		i_reset = 1'b1;
		i_wr = 1'b0;
		i_rd = 1'b0;
		i_data = '0;
		repeat (4) @(posedge i_clk);
		#1 i_reset = 1'b0;

		// Reads on an empty buffer are ignored
		check_level('0, 1'b0, 1'b1);
		drive(1'b0, 1'b1, '0);
		drive(1'b0, 1'b1, '0);
		drive(1'b0, 1'b0, '0);
		check_level('0, 1'b0, 1'b1);

		test_name = "in_order";
		write_words(20);
		check_level(total_fill_t'(20), 1'b0, 1'b0);
		drain_words(20);
		check_level('0, 1'b0, 1'b1);

		// Words 33 to 40 are dropped
		test_name = "capacity";
		write_words(40);
		sent_q = sent_q[0:CAPACITY-1];
		check_level(total_fill_t'(CAPACITY), 1'b1, 1'b0);
		drain_words(CAPACITY);
		check_level('0, 1'b0, 1'b1);

		// Write with read while full loses the write
		test_name = "full_read_write";
		write_words(CAPACITY);
		drive(1'b1, 1'b1, 8'hA5);
		void'(sent_q.pop_front());
		drive(1'b1, 1'b0, 8'h5A);
		check_level(total_fill_t'(CAPACITY - 1), 1'b0, 1'b0);
		sent_q.push_back(8'h5A);
		drive(1'b0, 1'b0, '0);
		check_level(total_fill_t'(CAPACITY), 1'b1, 1'b0);
		drain_words(CAPACITY);

		// Checked each cycle by the compare process
		test_name = "random";
		for (int i = 0; i < RAND_CYCLES; i++) begin
			r = next_rand();
			drive(r[0], r[1], r[15:8]);
		end
		drive(1'b0, 1'b0, '0);
		repeat (2) @(negedge i_clk);

		if (lane_sva_bad == '0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "errors recorded during the run");
		end
	end

endmodule

`default_nettype wire

/* verilog/fifo_lane_if.sv */
// One lane's strobes and status, with no gating, so the writer and reader must respect the flags
`timescale 1ns/1ps
`default_nettype none

interface fifo_lane_if;
	import stripe_data_pkg::*;
	import stripe_lane_pkg::*;

	// Write side
	logic		wr;
	word_t		wdata;

	// Read side
	logic		rd;

	// Lane status
	logic		full;
	lane_fill_t	fill;
	logic		empty;
	word_t		rdata;

	// Distributor end
	modport writer (output wr, output wdata, input full);

	// Collector end, fill is needed for the total count
	modport reader (output rd, input empty, input rdata, input fill);

	// The FIFO lane itself
	modport lane (
		input wr, input wdata, input rd,
		output full, output fill, output empty, output rdata
	);

endinterface

`default_nettype wire

/* verilog/lane_collector.sv */
// Reads lanes in the distributor's order, so both pointers must start at lane 0 from the same reset
`timescale 1ns/1ps
`default_nettype none

`include "stripe_cfg.svh"

module lane_collector (
	input  wire				i_clk,
	input  wire				i_reset,
	input  wire				i_rd,
	output stripe_data_pkg::word_t		o_data,
	output logic				o_empty,
	output stripe_lane_pkg::total_fill_t	o_fill,
	fifo_lane_if.reader			lanes [`STRIPE_LANES]
);
	import stripe_data_pkg::*;
	import stripe_lane_pkg::*;

	// Lane holding the oldest word
	lane_idx_t			rd_ptr;

	// Status gathered from the lane array
	logic [`STRIPE_LANES-1:0]	lane_empty;
	word_t				lane_rdata [`STRIPE_LANES];
	lane_fill_t			lane_fill [`STRIPE_LANES];

	logic				accept;

	//////////////////////////////////////////////////
	// Per-lane gather
	//////////////////////////////////////////////////

	for (genvar g = 0; g < `STRIPE_LANES; g++) begin : g_lane
		assign lane_empty[g] = lanes[g].empty;
		assign lane_rdata[g] = lanes[g].rdata;
		assign lane_fill[g] = lanes[g].fill;
		// Pop only the current lane
		assign lanes[g].rd = accept && (rd_ptr == lane_idx_t'(g));
	end

	//////////////////////////////////////////////////
	// Head of the buffer
	//////////////////////////////////////////////////

	// Oldest word always sits at the head of the pointed lane
	assign o_data = lane_rdata[rd_ptr];
	assign o_empty = lane_empty[rd_ptr];
	assign accept = i_rd && !o_empty;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			rd_ptr <= '0;
		end else if (accept) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Total occupancy
	// combinational over registered lane fills
	always_comb begin
		o_fill = '0;
		for (int i = 0; i < `STRIPE_LANES; i++) begin
			o_fill = o_fill + total_fill_t'(lane_fill[i]);
		end
	end

endmodule

`default_nettype wire

/* verilog/lane_distributor.sv */
// Deals writes round-robin, so lanes stay balanced only if every lane is written through this block
`timescale 1ns/1ps
`default_nettype none

`include "stripe_cfg.svh"

module lane_distributor (
	input  wire				i_clk,
	input  wire				i_reset,
	input  wire				i_wr,
	input  stripe_data_pkg::word_t		i_data,
	output logic				o_full,
	fifo_lane_if.writer			lanes [`STRIPE_LANES]
);
	import stripe_lane_pkg::*;

	// Lane that takes the next word
	lane_idx_t			wr_ptr;

	// Full flags gathered from the lane array
	logic [`STRIPE_LANES-1:0]	lane_full;

	// Write accepted this cycle
	logic				accept;

	//////////////////////////////////////////////////
	// Per-lane steering
	//////////////////////////////////////////////////

	// Interface arrays need constant indices
	// so fan out and gather in a generate loop
	for (genvar g = 0; g < `STRIPE_LANES; g++) begin : g_lane
		assign lane_full[g] = lanes[g].full;
		// Only the lane under the pointer sees a strobe
		assign lanes[g].wr = accept && (wr_ptr == lane_idx_t'(g));
		// Data broadcast, harmless without the strobe
		assign lanes[g].wdata = i_data;
	end

	//////////////////////////////////////////////////
	// Acceptance and pointer
	//////////////////////////////////////////////////

	// Balanced lanes, so the pointed lane is full only when all are
	assign o_full = lane_full[wr_ptr];
	assign accept = i_wr && !o_full;

	// Step to the next lane on each accepted write
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			wr_ptr <= '0;
		end else if (accept) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/lane_fifo.sv */
// Async-read FIFO lane that trusts its strobes, so a write while full or read while empty corrupts it
`timescale 1ns/1ps
`default_nettype none

`include "stripe_cfg.svh"

module lane_fifo (
	input  wire		i_clk,
	input  wire		i_reset,
	fifo_lane_if.lane	lane
);
	import stripe_data_pkg::*;
	import stripe_lane_pkg::*;

	localparam int unsigned LG = `STRIPE_LG_DEPTH;

	// Fill values that the full flag is judged against
	localparam lane_fill_t FILL_FULL = lane_fill_t'(LANE_DEPTH);
	localparam lane_fill_t FILL_ALMOST = lane_fill_t'(LANE_DEPTH - 1);

	//////////////////////////////////////////////////
	// Storage and pointers
	//////////////////////////////////////////////////

	word_t		mem [LANE_DEPTH];

	// One bit wider than the index
	// MSB tells a wrapped pointer from an unwrapped one
	lane_fill_t	wr_addr;
	lane_fill_t	rd_addr;

	// Registered status
	lane_fill_t	fill_q;
	logic		full_q;

	//////////////////////////////////////////////////
	// Occupancy
	//////////////////////////////////////////////////

	// Count up on write, down on read
	// Both or neither, resync from the pointers
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			fill_q <= '0;
		end else begin
			case ({lane.wr, lane.rd})
				2'b01: fill_q <= fill_q - 1'b1;
				2'b10: fill_q <= fill_q + 1'b1;
				default: fill_q <= wr_addr - rd_addr;
			endcase
		end
	end

	// Full registered alongside fill
	// so the flag is not a compare on the output path
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			full_q <= 1'b0;
		end else begin
			case ({lane.wr, lane.rd})
				// Any lone read leaves room
				2'b01: full_q <= 1'b0;
				// Last free slot about to be taken
				2'b10: full_q <= (fill_q == FILL_ALMOST);
				// Level unchanged
				default: full_q <= (fill_q == FILL_FULL);
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			wr_addr <= '0;
		end else if (lane.wr) begin
			wr_addr <= wr_addr + 1'b1;
		end
	end

	// Payload memory, no reset
	always_ff @(posedge i_clk) begin
		if (lane.wr) begin
			mem[wr_addr[LG-1:0]] <= lane.wdata;
		end
	end

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			rd_addr <= '0;
		end else if (lane.rd) begin
			rd_addr <= rd_addr + 1'b1;
		end
	end

	// Head word straight out of memory
	// valid whenever the lane is not empty
	assign lane.rdata = mem[rd_addr[LG-1:0]];

	// Status out to the interface
	assign lane.empty = (fill_q == '0);
	assign lane.fill = fill_q;
	assign lane.full = full_q;

endmodule

`default_nettype wire

/* verilog/stripe_buffer.sv */
// In-order FIFO of lanes times depth words, o_data is combinational and valid only while o_empty is low
`timescale 1ns/1ps
`default_nettype none

`include "stripe_cfg.svh"

module stripe_buffer (
	input  wire				i_clk,
	input  wire				i_reset,

	// Write port
	input  wire				i_wr,
	input  stripe_data_pkg::word_t		i_data,
	output logic				o_full,

	// Read port
	input  wire				i_rd,
	output stripe_data_pkg::word_t		o_data,
	output logic				o_empty,

	// Words held, one cycle behind the strobes
	output stripe_lane_pkg::total_fill_t	o_fill
);

	//////////////////////////////////////////////////
	// Lane buses
	//////////////////////////////////////////////////

	// One bus per lane
	// written by the distributor, read by the collector
	fifo_lane_if lane_bus [`STRIPE_LANES] ();

	//////////////////////////////////////////////////
	// Write dealer
	//////////////////////////////////////////////////

	lane_distributor u_dist (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_wr		(i_wr),
		.i_data		(i_data),
		.o_full		(o_full),
		.lanes		(lane_bus)
	);

	//////////////////////////////////////////////////
	// FIFO lanes
	//////////////////////////////////////////////////

	// Identical lanes, narrow and shallow each
	for (genvar g = 0; g < `STRIPE_LANES; g++) begin : g_lane
		lane_fifo u_fifo (
			.i_clk		(i_clk),
			.i_reset	(i_reset),
			.lane		(lane_bus[g])
		);
	end

	//////////////////////////////////////////////////
	// Read gatherer
	//////////////////////////////////////////////////

	// Same dealing order on the way out
	// keeps the whole block in order
	lane_collector u_coll (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_rd		(i_rd),
		.o_data		(o_data),
		.o_empty	(o_empty),
		.o_fill		(o_fill),
		.lanes		(lane_bus)
	);

endmodule

`default_nettype wire

/* verilog/stripe_data_pkg.sv */
// Payload types only, with word width taken from the cfg header and no bus framing
`default_nettype none

`include "stripe_cfg.svh"

package stripe_data_pkg;

	//////////////////////////////////////////////////
	// Payload
	//////////////////////////////////////////////////

	// Width of one data word
	localparam int unsigned WORD_W = `STRIPE_DATA_W;

	// One data word as it moves through the lanes
	typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

/* verilog/stripe_lane_pkg.sv */
// Lane bookkeeping types, sized for a power-of-two lane count of at least 2
`default_nettype none

`include "stripe_cfg.svh"

package stripe_lane_pkg;

	//////////////////////////////////////////////////
	// Lane geometry
	//////////////////////////////////////////////////

	localparam int unsigned LANE_IDX_W = $clog2(`STRIPE_LANES);
	// Words per lane
	localparam int unsigned LANE_DEPTH = 1 << `STRIPE_LG_DEPTH;

	// Round-robin pointer, wraps on its own
	typedef logic [LANE_IDX_W-1:0] lane_idx_t;

	// One spare bit so a full lane is distinct from an empty one
	typedef logic [`STRIPE_LG_DEPTH:0] lane_fill_t;

	// Sum of all lanes, up to lanes times depth
	typedef logic [`STRIPE_LG_DEPTH+LANE_IDX_W:0] total_fill_t;

endpackage

`default_nettype wire

/* vlog.f */
+incdir+include
verilog/stripe_data_pkg.sv
verilog/stripe_lane_pkg.sv
verilog/fifo_lane_if.sv
verilog/lane_fifo.sv
verilog/lane_distributor.sv
verilog/lane_collector.sv
verilog/stripe_buffer.sv
tests/stripe_buffer_sva.sv
tests/stripe_buffer_tb.sv
